// File: src.f
+incdir+include
src/p65FlagPkg.sv
src/flagDecode.sv
src/flagExecute.sv
src/interruptVector.sv
src/p65FlagCore.sv
dv/flagCoreTb.sv

// File: include/flagCoreVectors.svh
`ifndef FLAG_CORE_VECTORS_SVH
`define FLAG_CORE_VECTORS_SVH

// One instruction with its interrupt pins and what should come back
// Expected status is the value once the row is done, interrupt entry included
typedef struct packed {
  logic [7:0]  opcode;
  logic [7:0]  operand;
  logic        nmiN;
  logic        irqN;
  logic [8:0]  expStatus;
  logic        expTaken;
  logic        expVector;
  logic [15:0] expVecAddr;
} flagRowT;

// Vector seen before any instruction retires
localparam logic [15:0] RESET_VECTOR = 16'hFFFC;

// Emulation with E, M, X and I set, everything else clear
localparam logic [8:0] RESET_STATUS = 9'h134;

localparam int NUM_ROWS = 37;

localparam flagRowT FLAG_ROWS [NUM_ROWS] = '{
  '{8'h38, 8'h00, 1'b1, 1'b1, 9'h135, 1'b0, 1'b0, 16'h0000},
  '{8'hF8, 8'h00, 1'b1, 1'b1, 9'h13D, 1'b0, 1'b0, 16'h0000},
  '{8'hD8, 8'h00, 1'b1, 1'b1, 9'h135, 1'b0, 1'b0, 16'h0000},
  '{8'h58, 8'h00, 1'b1, 1'b1, 9'h131, 1'b0, 1'b0, 16'h0000},
  '{8'h78, 8'h00, 1'b1, 1'b1, 9'h135, 1'b0, 1'b0, 16'h0000},
  // Emulation keeps M and X through REP and PLP
  '{8'hC2, 8'hFF, 1'b1, 1'b1, 9'h130, 1'b0, 1'b0, 16'h0000},
  '{8'hE2, 8'hC3, 1'b1, 1'b1, 9'h1F3, 1'b0, 1'b0, 16'h0000},
  '{8'hB8, 8'h00, 1'b1, 1'b1, 9'h1B3, 1'b0, 1'b0, 16'h0000},
  '{8'h28, 8'h00, 1'b1, 1'b1, 9'h130, 1'b0, 1'b0, 16'h0000},
  // All flags clear for the first branch sweep
  '{8'h70, 8'h00, 1'b1, 1'b1, 9'h130, 1'b0, 1'b0, 16'h0000},
  '{8'h50, 8'h00, 1'b1, 1'b1, 9'h130, 1'b1, 1'b0, 16'h0000},
  '{8'h10, 8'h00, 1'b1, 1'b1, 9'h130, 1'b1, 1'b0, 16'h0000},
  '{8'h30, 8'h00, 1'b1, 1'b1, 9'h130, 1'b0, 1'b0, 16'h0000},
  '{8'h90, 8'h00, 1'b1, 1'b1, 9'h130, 1'b1, 1'b0, 16'h0000},
  '{8'hB0, 8'h00, 1'b1, 1'b1, 9'h130, 1'b0, 1'b0, 16'h0000},
  '{8'hD0, 8'h00, 1'b1, 1'b1, 9'h130, 1'b1, 1'b0, 16'h0000},
  '{8'hF0, 8'h00, 1'b1, 1'b1, 9'h130, 1'b0, 1'b0, 16'h0000},
  // Into native mode
  '{8'h18, 8'h00, 1'b1, 1'b1, 9'h130, 1'b0, 1'b0, 16'h0000},
  '{8'hFB, 8'h00, 1'b1, 1'b1, 9'h031, 1'b0, 1'b0, 16'h0000},
  '{8'hC2, 8'h30, 1'b1, 1'b1, 9'h001, 1'b0, 1'b0, 16'h0000},
  '{8'hB0, 8'h00, 1'b1, 1'b1, 9'h001, 1'b1, 1'b0, 16'h0000},
  '{8'hE2, 8'h82, 1'b1, 1'b1, 9'h083, 1'b0, 1'b0, 16'h0000},
  '{8'hF0, 8'h00, 1'b1, 1'b1, 9'h083, 1'b1, 1'b0, 16'h0000},
  '{8'h30, 8'h00, 1'b1, 1'b1, 9'h083, 1'b1, 1'b0, 16'h0000},
  '{8'h28, 8'h0C, 1'b1, 1'b1, 9'h00C, 1'b0, 1'b0, 16'h0000},
  '{8'hD0, 8'h00, 1'b1, 1'b1, 9'h00C, 1'b1, 1'b0, 16'h0000},
  // Native software and hardware interrupts
  '{8'h00, 8'h00, 1'b1, 1'b1, 9'h004, 1'b0, 1'b1, 16'hFFE6},
  '{8'h02, 8'h00, 1'b1, 1'b1, 9'h004, 1'b0, 1'b1, 16'hFFE4},
  '{8'h58, 8'h00, 1'b1, 1'b0, 9'h004, 1'b0, 1'b1, 16'hFFEE},
  '{8'h58, 8'h00, 1'b0, 1'b0, 9'h004, 1'b0, 1'b1, 16'hFFEA},
  '{8'hEA, 8'h00, 1'b1, 1'b1, 9'h004, 1'b0, 1'b0, 16'h0000},
  // Back to emulation
  '{8'h38, 8'h00, 1'b1, 1'b1, 9'h005, 1'b0, 1'b0, 16'h0000},
  '{8'hFB, 8'h00, 1'b1, 1'b1, 9'h134, 1'b0, 1'b0, 16'h0000},
  '{8'hC2, 8'h30, 1'b1, 1'b1, 9'h134, 1'b0, 1'b0, 16'h0000},
  '{8'h28, 8'h00, 1'b1, 1'b1, 9'h130, 1'b0, 1'b0, 16'h0000},
  '{8'h00, 8'h00, 1'b1, 1'b1, 9'h134, 1'b0, 1'b1, 16'hFFFE},
  '{8'h02, 8'h00, 1'b1, 1'b1, 9'h134, 1'b0, 1'b1, 16'hFFF4}
};

`endif

// File: dv/flagCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module flagCoreTb
  import p65FlagPkg::*;
();

  `include "flagCoreVectors.svh"

  // Cycles any single wait may take before the run is declared hung
  localparam int WAIT_LIMIT = 64;

  logic    CLK;
  logic    RST_N;
  logic    ready;
  logic    opValid;
  opcodeT  opcode;
  byteT    operand;
  logic    nmiN;
  logic    irqN;
  statusT  status;
  logic    resultValid;
  logic    branchTaken;
  logic    vectorValid;
  vecAddrT vectorAddr;

  int   resultCount;
  int   vectorCount;
  int   doneRows;
  logic resetChecked;

  p65FlagCore #(
    .VECTOR_PAGE (8'hFF)
  ) dut0 (
    .CLK         (CLK),
    .RST_N       (RST_N),
    .ready       (ready),
    .opValid     (opValid),
    .opcode      (opcode),
    .operand     (operand),
    .nmiN        (nmiN),
    .irqN        (irqN),
    .status      (status),
    .resultValid (resultValid),
    .branchTaken (branchTaken),
    .vectorValid (vectorValid),
    .vectorAddr  (vectorAddr)
  );

  initial
  begin
    CLK = 1'b0;
    forever
    begin
      #2 CLK = ~CLK;
    end
  end

  // Every pulse is counted so duplicates show up at the end
  always @(posedge CLK)
  begin
    if (resultValid)
      resultCount++;
    if (vectorValid)
      vectorCount++;
  end

  task automatic failRun();
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkStatus(input string tag, input statusT got, input statusT exp);
    if (got !== exp)
    begin
      $display("ERROR status %s: got 0x%03h, expected 0x%03h", tag, got, exp);
      failRun();
    end
  endtask

  task automatic checkVector(input string tag, input vecAddrT got, input vecAddrT exp);
    if (got !== exp)
    begin
      $display("ERROR vectorAddr %s: got 0x%04h, expected 0x%04h", tag, got, exp);
      failRun();
    end
  endtask

  task automatic checkTaken(input string tag, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR branchTaken %s: got 0x%0h, expected 0x%0h", tag, got, exp);
      failRun();
    end
  endtask

  // Outputs are sampled on the rising edge, before the DUT updates them
  task automatic waitResult(input int row);
    int cycles;
    cycles = 0;
    do
    begin
      @(posedge CLK);
      cycles++;
      if (cycles > WAIT_LIMIT)
      begin
        $display("Timeout: resultValid never arrived for row %0d", row);
        failRun();
      end
    end
    while (!resultValid);
  endtask

  task automatic waitVector(input string tag);
    int cycles;
    cycles = 0;
    do
    begin
      @(posedge CLK);
      cycles++;
      if (cycles > WAIT_LIMIT)
      begin
        $display("Timeout: vectorValid never arrived %s", tag);
        failRun();
      end
    end
    while (!vectorValid);
  endtask

  function automatic logic isBranch(input opcodeT opc);
    return opc[4:0] == 5'b10000;
  endfunction

  // Rows without vectors and with unchanged interrupt pins may overlap
  function automatic logic canPipeline(input int row);
    if (row == 0)
      return 1'b0;
    return !FLAG_ROWS[row].expVector && !FLAG_ROWS[row - 1].expVector
           && FLAG_ROWS[row].nmiN == FLAG_ROWS[row - 1].nmiN
           && FLAG_ROWS[row].irqN == FLAG_ROWS[row - 1].irqN;
  endfunction

  function automatic int expectedVectors();
    int total;
    total = 1;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      if (FLAG_ROWS[i].expVector)
        total++;
    end
    return total;
  endfunction

  // Wait for older rows to finish while ready toggles at random
  task automatic drainPipe(input int row);
    int cycles;
    cycles = 0;
    while (!(resetChecked && doneRows >= row))
    begin
      ready = ($urandom % 4) != 0;
      opValid = 1'b0;
      @(negedge CLK);
      cycles++;
      if (cycles > WAIT_LIMIT)
      begin
        $display("Timeout: earlier instructions never finished before row %0d", row);
        failRun();
      end
    end
  endtask

  task automatic insertStalls();
    int n;
    n = ($urandom % 3 == 0) ? 1 + $urandom % 3 : 0;
    repeat (n)
    begin
      ready = 1'b0;
      opValid = 1'b0;
      @(negedge CLK);
    end
  endtask

  task automatic issueRow(input int row);
    ready = 1'b1;
    opValid = 1'b1;
    opcode = FLAG_ROWS[row].opcode;
    operand = FLAG_ROWS[row].operand;
    nmiN = FLAG_ROWS[row].nmiN;
    irqN = FLAG_ROWS[row].irqN;
    @(negedge CLK);
  endtask

  task automatic driveRows();
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      if (!canPipeline(i))
        drainPipe(i);
      else if (!isBranch(FLAG_ROWS[i].opcode))
        insertStalls();
      // Branches go right behind the flag op they test
      issueRow(i);
    end
    opValid = 1'b0;
    ready = 1'b1;
  endtask

  task automatic checkRows();
    string tag;
    waitVector("after reset");
    checkVector("after reset", vectorAddr, RESET_VECTOR);
    checkStatus("after reset", status, RESET_STATUS);
    resetChecked = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      tag = $sformatf("row %0d", i);
      waitResult(i);
      checkTaken(tag, branchTaken, FLAG_ROWS[i].expTaken);
      // Interrupt entry lands on the vector edge, so status is checked after it
      if (FLAG_ROWS[i].expVector)
      begin
        waitVector(tag);
        checkVector(tag, vectorAddr, FLAG_ROWS[i].expVecAddr);
      end
      checkStatus(tag, status, FLAG_ROWS[i].expStatus);
      doneRows = i + 1;
    end
  endtask

  initial
  begin
    void'($urandom(32'hce3d3fec));
    RST_N = 1'b0;
    ready = 1'b1;
    opValid = 1'b0;
    opcode = 8'h00;
    operand = 8'h00;
    nmiN = 1'b1;
    irqN = 1'b1;
    resultCount = 0;
    vectorCount = 0;
    doneRows = 0;
    resetChecked = 1'b0;
    // Five full clock periods in reset, released on a falling edge
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST_N = 1'b1;
    fork
      driveRows();
      checkRows();
    join
    // Let any stray pulse show up in the counters
    repeat (8) @(posedge CLK);
    if (resultCount == NUM_ROWS && vectorCount == expectedVectors())
    begin
      $display("Simulation completed successfully");
      $finish;
    end
    else
    begin
      $display("ERROR pulse count: resultValid got 0x%0h, expected 0x%0h",
               resultCount, NUM_ROWS);
      $display("ERROR pulse count: vectorValid got 0x%0h, expected 0x%0h",
               vectorCount, expectedVectors());
      failRun();
    end
  end

endmodule

`default_nettype wire

// File: src/p65FlagCore.sv
`timescale 1ns/1ps
`default_nettype none

module p65FlagCore
  import p65FlagPkg::*;
#(
  parameter logic [7:0] VECTOR_PAGE = 8'hFF
)
(
  input  wire         CLK,
  input  wire         RST_N,
  input  wire         ready,
  input  wire         opValid,
  input  wire opcodeT opcode,
  input  wire byteT   operand,
  input  wire         nmiN,
  input  wire         irqN,
  output statusT      status,
  output logic        resultValid,
  output logic        branchTaken,
  output logic        vectorValid,
  output vecAddrT     vectorAddr
);

  // Decode to execute
  logic       decValid;
  flagOpT     decOp;
  logic [2:0] decBitSel;
  logic       decValue;
  byteT       decMask;
  logic [2:0] decCond;

  // Execute to vector stage and back
  logic       retireValid;
  retireKindT retireKind;
  logic       intTake;

  flagDecode decodeStage (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .ready     (ready),
    .opValid   (opValid),
    .opcode    (opcode),
    .operand   (operand),
    .decValid  (decValid),
    .decOp     (decOp),
    .decBitSel (decBitSel),
    .decValue  (decValue),
    .decMask   (decMask),
    .decCond   (decCond)
  );

  flagExecute executeStage (
    .CLK         (CLK),
    .RST_N       (RST_N),
    .ready       (ready),
    .decValid    (decValid),
    .decOp       (decOp),
    .decBitSel   (decBitSel),
    .decValue    (decValue),
    .decMask     (decMask),
    .decCond     (decCond),
    .intTake     (intTake),
    .status      (status),
    .resultValid (resultValid),
    .branchTaken (branchTaken),
    .retireValid (retireValid),
    .retireKind  (retireKind)
  );

  interruptVector #(
    .VECTOR_PAGE (VECTOR_PAGE)
  ) vectorStage (
    .CLK         (CLK),
    .RST_N       (RST_N),
    .ready       (ready),
    .nmiN        (nmiN),
    .irqN        (irqN),
    .retireValid (retireValid),
    .retireKind  (retireKind),
    .status      (status),
    .intTake     (intTake),
    .vectorValid (vectorValid),
    .vectorAddr  (vectorAddr)
  );

endmodule

`default_nettype wire

// File: src/interruptVector.sv
`timescale 1ns/1ps
`default_nettype none

module interruptVector
  import p65FlagPkg::*;
#(
  parameter logic [7:0] VECTOR_PAGE = 8'hFF
)
(
  input  wire             CLK,
  input  wire             RST_N,
  input  wire             ready,
  input  wire             nmiN,
  input  wire             irqN,
  input  wire             retireValid,
  input  wire retireKindT retireKind,
  input  wire statusT     status,
  output logic            intTake,
  output logic            vectorValid,
  output vecAddrT         vectorAddr
);

  logic       nmiSample;
  logic       nmiLast;
  logic       nmiFall;
  logic       nmiPending;
  logic       irqActive;
  logic       resetPending;
  logic       takeNmi;
  logic       takeIrq;
  logic       takeSoft;
  logic       vectorNow;
  logic       validQ;
  logic       emu;
  logic [3:0] lowNibble;

  // NMI is edge triggered, so compare two successive samples
  assign nmiFall = nmiLast && !nmiSample;

  assign emu = status[BIT_E];

  // Status here is what the retiring instruction left behind
  assign takeNmi = retireValid && !resetPending && nmiPending;
  assign takeIrq = retireValid && !resetPending && !nmiPending && irqActive
                   && !status[BIT_I];
  assign takeSoft = retireValid && !resetPending && (retireKind != RetNormal);

  assign intTake = takeNmi || takeIrq;
  assign vectorNow = resetPending || intTake || takeSoft;

  // Priority is reset, NMI, IRQ, COP, BRK
  always_comb
  begin
    if (resetPending)
      lowNibble = 4'hC;
    else if (takeNmi)
      lowNibble = 4'hA;
    else if (takeIrq)
      lowNibble = 4'hE;
    else if (retireKind == RetCop)
      lowNibble = 4'h4;
    else if (emu)
      lowNibble = 4'hE;
    else
      lowNibble = 4'h6;
  end

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      nmiSample <= 1'b1;
      nmiLast <= 1'b1;
      nmiPending <= 1'b0;
      irqActive <= 1'b0;
      resetPending <= 1'b1;
      validQ <= 1'b0;
    end
    else if (ready)
    begin
      nmiSample <= nmiN;
      nmiLast <= nmiSample;
      irqActive <= !irqN;
      // Reset vector goes out on the first ready edge
      resetPending <= 1'b0;
      validQ <= vectorNow;
      // A new falling edge beats the clear of the one being serviced
      if (nmiFall)
        nmiPending <= 1'b1;
      else if (takeNmi)
        nmiPending <= 1'b0;
    end
  end

  // Page-low nibble is E in native mode and F in emulation
  always_ff @(posedge CLK)
  begin
    if (ready && vectorNow)
      vectorAddr <= {VECTOR_PAGE, 3'b111, emu, lowNibble};
  end

  assign vectorValid = validQ && ready;

  // Vectors are word pointers
  vecAligned: assert property (@(posedge CLK) disable iff (!RST_N)
    vectorValid |-> !vectorAddr[0]);

endmodule

`default_nettype wire

// File: src/flagExecute.sv
`timescale 1ns/1ps
`default_nettype none

module flagExecute
  import p65FlagPkg::*;
(
  input  wire         CLK,
  input  wire         RST_N,
  input  wire         ready,
  input  wire         decValid,
  input  wire flagOpT decOp,
  input  wire [2:0]   decBitSel,
  input  wire         decValue,
  input  wire byteT   decMask,
  input  wire [2:0]   decCond,
  input  wire         intTake,
  output statusT      status,
  output logic        resultValid,
  output logic        branchTaken,
  output logic        retireValid,
  output retireKindT  retireKind
);

  localparam byteT MX_MASK = byteT'((1 << BIT_M) | (1 << BIT_X));

  statusT     nextStatus;
  byteT       maskEff;
  retireKindT kindNow;
  logic       emu;
  logic       condFlag;
  logic       takenNow;
  logic       validQ;

  assign emu = status[BIT_E];

  // In emulation REP and SEP leave M and X alone
  assign maskEff = emu ? (decMask & ~MX_MASK) : decMask;

  // Condition field picks N, V, C or Z, low bit says taken-if-set
  always_comb
  begin
    case (decCond[2:1])
      2'b00:
        condFlag = status[BIT_N];
      2'b01:
        condFlag = status[BIT_V];
      2'b10:
        condFlag = status[BIT_C];
      default:
        condFlag = status[BIT_Z];
    endcase
  end

  assign takenNow = decValid && (decOp == OpBranch) && (condFlag == decCond[0]);

  always_comb
  begin
    nextStatus = status;
    if (decValid)
    begin
      case (decOp)
        OpSetBit, OpClrBit:
          nextStatus[decBitSel] = decValue;
        OpRep:
          nextStatus[7:0] = status[7:0] & ~maskEff;
        OpSep:
          nextStatus[7:0] = status[7:0] | maskEff;
        OpPlp:
        begin
          nextStatus[7:0] = decMask;
          if (emu)
          begin
            nextStatus[BIT_M] = 1'b1;
            nextStatus[BIT_X] = 1'b1;
          end
        end
        OpXce:
        begin
          nextStatus[BIT_E] = status[BIT_C];
          nextStatus[BIT_C] = status[BIT_E];
          // Entering emulation forces 8-bit registers
          if (status[BIT_C])
          begin
            nextStatus[BIT_M] = 1'b1;
            nextStatus[BIT_X] = 1'b1;
          end
        end
        OpBrk, OpCop:
        begin
          nextStatus[BIT_I] = 1'b1;
          nextStatus[BIT_D] = 1'b0;
        end
        default:
        begin
        end
      endcase
    end
    // Hardware interrupt entry stacks on top of this cycle's instruction
    if (intTake)
    begin
      nextStatus[BIT_I] = 1'b1;
      nextStatus[BIT_D] = 1'b0;
    end
  end

  always_comb
  begin
    kindNow = RetNormal;
    if (decValid && decOp == OpBrk)
      kindNow = RetBrk;
    else if (decValid && decOp == OpCop)
      kindNow = RetCop;
  end

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      status <= STATUS_RESET;
      validQ <= 1'b0;
      branchTaken <= 1'b0;
      retireKind <= RetNormal;
    end
    else if (ready)
    begin
      status <= nextStatus;
      validQ <= decValid;
      branchTaken <= takenNow;
      retireKind <= kindNow;
    end
  end

  // Held result shows on the first cycle ready is high
  assign resultValid = validQ && ready;
  assign retireValid = validQ;

  // Emulation mode never runs with 16-bit A or index registers
  emuForcesMx: assert property (@(posedge CLK) disable iff (!RST_N)
    status[BIT_E] |-> (status[BIT_M] && status[BIT_X]));

endmodule

`default_nettype wire

// File: src/flagDecode.sv
`timescale 1ns/1ps
`default_nettype none

module flagDecode
  import p65FlagPkg::*;
(
  input  wire         CLK,
  input  wire         RST_N,
  input  wire         ready,
  input  wire         opValid,
  input  wire opcodeT opcode,
  input  wire byteT   operand,
  output logic        decValid,
  output flagOpT      decOp,
  output logic [2:0]  decBitSel,
  output logic        decValue,
  output byteT        decMask,
  output logic [2:0]  decCond
);

  localparam opcodeT OPC_TYA = 8'h98;
  localparam opcodeT OPC_REP = 8'hC2;
  localparam opcodeT OPC_SEP = 8'hE2;
  localparam opcodeT OPC_PLP = 8'h28;
  localparam opcodeT OPC_XCE = 8'hFB;
  localparam opcodeT OPC_BRK = 8'h00;
  localparam opcodeT OPC_COP = 8'h02;

  flagOpT     nextOp;
  logic [2:0] nextBitSel;
  logic       nextValue;
  logic       accept;

  assign accept = ready && opValid;

  always_comb
  begin
    nextOp = OpNone;
    nextBitSel = 3'(BIT_C);
    // TYA shares the xx011000 pattern but touches no flag
    if (opcode[4:0] == 5'b11000 && opcode != OPC_TYA)
    begin
      // CLV is the one clear opcode with bit 5 high
      if (opcode[5] && opcode[7:6] != 2'b10)
        nextOp = OpSetBit;
      else
        nextOp = OpClrBit;
      case (opcode[7:6])
        2'b00:
          nextBitSel = 3'(BIT_C);
        2'b01:
          nextBitSel = 3'(BIT_I);
        2'b10:
          nextBitSel = 3'(BIT_V);
        default:
          nextBitSel = 3'(BIT_D);
      endcase
    end
    else if (opcode[4:0] == 5'b10000)
    begin
      nextOp = OpBranch;
    end
    else
    begin
      case (opcode)
        OPC_REP:
          nextOp = OpRep;
        OPC_SEP:
          nextOp = OpSep;
        OPC_PLP:
          nextOp = OpPlp;
        OPC_XCE:
          nextOp = OpXce;
        OPC_BRK:
          nextOp = OpBrk;
        OPC_COP:
          nextOp = OpCop;
        default:
          nextOp = OpNone;
      endcase
    end
  end

  assign nextValue = (nextOp == OpSetBit);

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
      decValid <= 1'b0;
    else if (ready)
      decValid <= opValid;
  end

  // Operation fields only load behind an accepted opcode
  always_ff @(posedge CLK)
  begin
    if (accept)
    begin
      decOp <= nextOp;
      decBitSel <= nextBitSel;
      decValue <= nextValue;
      decMask <= operand;
      decCond <= opcode[7:5];
    end
  end

  // A fresh decoded op appears only one edge after an accepted opcode
  decAcceptedOnly: assert property (@(posedge CLK) disable iff (!RST_N)
    $rose(decValid) |-> $past(ready && opValid));

endmodule

`default_nettype wire

// File: src/p65FlagPkg.sv
`default_nettype none

package p65FlagPkg;

  // Instruction stream widths
  typedef logic [7:0] opcodeT;
  typedef logic [7:0] byteT;

  // Status register is E on top of the eight classic flags
  typedef logic [8:0] statusT;

  // Vector fetch address inside bank 0
  typedef logic [15:0] vecAddrT;

  // Status bit positions
  localparam int BIT_C = 0;
  localparam int BIT_Z = 1;
  localparam int BIT_I = 2;
  localparam int BIT_D = 3;
  localparam int BIT_X = 4;
  localparam int BIT_M = 5;
  localparam int BIT_V = 6;
  localparam int BIT_N = 7;
  localparam int BIT_E = 8;

  // Out of reset the core is in emulation mode with 8-bit registers and IRQ masked
  localparam statusT STATUS_RESET = 9'b1_0011_0100;

  // Operation handed from decode to execute
  typedef enum logic [3:0] {
    OpNone,
    OpSetBit,
    OpClrBit,
    OpRep,
    OpSep,
    OpPlp,
    OpXce,
    OpBranch,
    OpBrk,
    OpCop
  } flagOpT;

  // What kind of instruction left the execute stage
  typedef enum logic [1:0] {
    RetNormal,
    RetBrk,
    RetCop
  } retireKindT;

endpackage

`default_nettype wire
